// ==== intlv_defs.svh ====
`ifndef INTLV_DEFS_SVH
`define INTLV_DEFS_SVH

// --------------------
// frame geometry
// --------------------

`define INTLV_ROWS     4   // rows per frame
`define INTLV_COLS     8   // columns per row, also the row length

// --------------------
// widths
// --------------------

`define INTLV_ADDR_W   5   // in-bank sample address, rows * cols = 32
`define INTLV_DAT_W    8   // one sample
`define INTLV_TAG_W    8   // frame number
`define INTLV_BNUM_W   1   // bank index, 2 banks for ping-pong

// --------------------
// output flow control
// --------------------

`define INTLV_CREDITS  4   // credits held by the reader out of reset

`endif

// ==== intlv_pkg.sv ====
`include "intlv_defs.svh"

package intlv_pkg;

  // payload types
  typedef logic [`INTLV_DAT_W-1:0]  sample_t;  // one sample
  typedef logic [`INTLV_TAG_W-1:0]  tag_t;     // frame tag

  // address / bank types
  typedef logic [`INTLV_ADDR_W-1:0] addr_t;    // address inside one bank
  typedef logic [`INTLV_BNUM_W-1:0] bank_t;    // bank index

  // credit count, must hold the full reset value
  typedef logic [$clog2(`INTLV_CREDITS+1)-1:0] credit_t;

  // reader fsm
  typedef enum logic {
    RD_IDLE,  // waiting for a closed bank
    RD_READ   // walking the bank column-major
  } rd_state_t;

endpackage

// ==== intlv_if.sv ====
// --------------------
// writer -> buffer
// --------------------

interface buf_wr_if;
  import intlv_pkg::*;

  logic    write;     // sample written this cycle
  addr_t   addr;      // in-bank address, row-major
  sample_t dat;
  tag_t    tag;       // frame tag, stored on close
  logic    close;     // current bank now holds a whole frame
  logic    full_all;  // every bank holds an unread frame

  modport writer (
    output write, addr, dat, tag, close,
    input  full_all
  );

  modport buffer (
    input  write, addr, dat, tag, close,
    output full_all
  );

endinterface

// --------------------
// buffer -> reader
// --------------------

interface buf_rd_if;
  import intlv_pkg::*;

  addr_t   addr;          // read address, column-major walk
  logic    release_bank;  // reader done with current bank
  sample_t dat;           // ram data, one cycle after addr
  tag_t    tag;           // tag of bank under read
  logic    empty_all;     // no bank holds a frame

  modport reader (
    output addr, release_bank,
    input  dat, tag, empty_all
  );

  modport buffer (
    input  addr, release_bank,
    output dat, tag, empty_all
  );

endinterface

// ==== bank_logic.sv ====
`include "intlv_defs.svh"

module bank_logic (
  input  logic             iwclk,
  input  logic             rst_n,
  input  logic             close,         // writer closed its bank
  input  logic             release_bank,  // reader finished its bank
  output intlv_pkg::bank_t wr_bank,
  output intlv_pkg::bank_t rd_bank,
  output logic             empty_all,
  output logic             full_all
);

  localparam int BANKS = 2 ** `INTLV_BNUM_W;

  // one extra bit so the counter can reach BANKS
  logic [`INTLV_BNUM_W:0] fill_q;  // number of closed, unread banks

  // --------------------
  // bank pointers
  // --------------------

  always_ff @(posedge iwclk) begin
    if (!rst_n) begin
      wr_bank <= '0;
      rd_bank <= '0;
    end else begin
      if (close)
        wr_bank <= wr_bank + 1'b1;  // round robin, toggles for 2 banks
      if (release_bank)
        rd_bank <= rd_bank + 1'b1;
    end
  end

  // --------------------
  // filled bank counter
  // --------------------

  always_ff @(posedge iwclk) begin
    if (!rst_n) begin
      fill_q <= '0;
    end else begin
      case ({close, release_bank})
        2'b10:   fill_q <= fill_q + 1'b1;  // one more frame waiting
        2'b01:   fill_q <= fill_q - 1'b1;  // one frame drained
        default: fill_q <= fill_q;         // none, or both at once
      endcase
    end
  end

  // flags straight from the counter
  assign empty_all = (fill_q == '0);
  assign full_all  = (fill_q == (`INTLV_BNUM_W+1)'(BANKS));

endmodule

// ==== frame_ram.sv ====
`include "intlv_defs.svh"

module frame_ram (
  input  logic                                    iwclk,
  input  logic                                    write,
  input  logic [`INTLV_ADDR_W+`INTLV_BNUM_W-1:0]  waddr,  // {bank, in-bank addr}
  input  intlv_pkg::sample_t                      wdat,
  input  logic [`INTLV_ADDR_W+`INTLV_BNUM_W-1:0]  raddr,
  output intlv_pkg::sample_t                      rdat    // one cycle after raddr
);
  import intlv_pkg::*;

  localparam int DEPTH = 2 ** (`INTLV_ADDR_W + `INTLV_BNUM_W);  // 64 samples

  sample_t mem [DEPTH];

  // write port
  always_ff @(posedge iwclk) begin
    if (write)
      mem[waddr] <= wdat;
  end

  // registered read port
  // writer and reader never share a bank, so no collision handling
  always_ff @(posedge iwclk) begin
    rdat <= mem[raddr];
  end

endmodule

// ==== codec_abuffer.sv ====
`include "intlv_defs.svh"

module codec_abuffer (
  input  logic     iwclk,
  input  logic     rst_n,
  buf_wr_if.buffer wr,
  buf_rd_if.buffer rd
);
  import intlv_pkg::*;

  localparam int BANKS = 2 ** `INTLV_BNUM_W;

  bank_t wr_bank;  // bank being filled
  bank_t rd_bank;  // bank being drained

  tag_t  tag_q [BANKS];  // one frame tag per bank

  // --------------------
  // bank control
  // --------------------

  bank_logic bank_logic_inst (
    .iwclk        (iwclk),
    .rst_n        (rst_n),
    .close        (wr.close),
    .release_bank (rd.release_bank),
    .wr_bank      (wr_bank),
    .rd_bank      (rd_bank),
    .empty_all    (rd.empty_all),
    .full_all     (wr.full_all)
  );

  // --------------------
  // sample memory
  // --------------------

  frame_ram frame_ram_inst (
    .iwclk (iwclk),
    .write (wr.write),
    .waddr ({wr_bank, wr.addr}),  // bank index on top
    .wdat  (wr.dat),
    .raddr ({rd_bank, rd.addr}),
    .rdat  (rd.dat)
  );

  // --------------------
  // tag registers
  // --------------------

  // loaded with the tag of the closing sample
  always_ff @(posedge iwclk) begin
    if (wr.close)
      tag_q[wr_bank] <= wr.tag;
  end

  assign rd.tag = tag_q[rd_bank];  // follows read pointer, no delay

endmodule

// ==== frame_writer.sv ====
`include "intlv_defs.svh"

module frame_writer (
  input  logic               iwclk,
  input  logic               rst_n,
  input  logic               in_valid,
  output logic               in_ready,
  input  intlv_pkg::sample_t in_data,
  input  intlv_pkg::tag_t    in_tag,
  buf_wr_if.writer           wr
);
  import intlv_pkg::*;

  localparam int ROW_W = $clog2(`INTLV_ROWS);
  localparam int COL_W = $clog2(`INTLV_COLS);

  logic [ROW_W-1:0] row_q;  // outer count
  logic [COL_W-1:0] col_q;  // inner count, moves every sample
  logic             xfer;   // handshake on this edge
  logic             col_end;
  logic             row_end;

  // --------------------
  // input handshake
  // --------------------

  assign in_ready = !wr.full_all;  // full banks are the back-pressure
  assign xfer     = in_valid && in_ready;

  assign col_end = (col_q == COL_W'(`INTLV_COLS - 1));
  assign row_end = (row_q == ROW_W'(`INTLV_ROWS - 1));

  // --------------------
  // row-major address counter
  // --------------------

  always_ff @(posedge iwclk) begin
    if (!rst_n) begin
      row_q <= '0;
      col_q <= '0;
    end else if (xfer) begin
      col_q <= col_end ? '0 : col_q + 1'b1;
      if (col_end)
        row_q <= row_end ? '0 : row_q + 1'b1;  // wraps after 32 samples
    end
  end

  // write straight through, ram takes it on the same edge
  assign wr.write = xfer;
  assign wr.addr  = addr_t'(row_q * `INTLV_COLS + col_q);
  assign wr.dat   = in_data;
  assign wr.tag   = in_tag;                       // last sample's tag wins
  assign wr.close = xfer && row_end && col_end;   // final write of frame

endmodule

// ==== frame_reader.sv ====
`include "intlv_defs.svh"

module frame_reader (
  input  logic               iwclk,
  input  logic               rst_n,
  buf_rd_if.reader           rd,
  output logic               out_valid,
  output intlv_pkg::sample_t out_data,
  output intlv_pkg::tag_t    out_tag,
  input  logic               out_credit  // one pulse per consumed word
);
  import intlv_pkg::*;

  localparam int ROW_W = $clog2(`INTLV_ROWS);
  localparam int COL_W = $clog2(`INTLV_COLS);

  rd_state_t        state_q;
  logic [ROW_W-1:0] row_q;    // inner count, column-major walk
  logic [COL_W-1:0] col_q;    // outer count
  credit_t          credits_q;
  tag_t             tag_q;    // tag of the word in flight
  logic             issue;    // address goes out this cycle
  logic             row_end;
  logic             col_end;
  logic             last;     // 32nd address of the bank

  assign row_end = (row_q == ROW_W'(`INTLV_ROWS - 1));
  assign col_end = (col_q == COL_W'(`INTLV_COLS - 1));
  assign last    = row_end && col_end;

  // only with a credit in hand
  assign issue = (state_q == RD_READ) && (credits_q != '0);

  // row * row length + col, rows move fastest
  assign rd.addr         = addr_t'(row_q * `INTLV_COLS + col_q);
  assign rd.release_bank = issue && last;  // frees bank at this edge

  // --------------------
  // fsm and counters
  // --------------------

  always_ff @(posedge iwclk) begin
    if (!rst_n) begin
      state_q <= RD_IDLE;
      row_q   <= '0;
      col_q   <= '0;
    end else begin
      case (state_q)
        RD_IDLE: if (!rd.empty_all) state_q <= RD_READ;  // a bank is closed
        RD_READ: if (issue && last) state_q <= RD_IDLE;  // recheck flags
        default: state_q <= RD_IDLE;
      endcase
      if (issue) begin
        row_q <= row_end ? '0 : row_q + 1'b1;
        if (row_end)
          col_q <= col_end ? '0 : col_q + 1'b1;
      end
    end
  end

  // --------------------
  // credits
  // --------------------

  always_ff @(posedge iwclk) begin
    if (!rst_n) begin
      credits_q <= credit_t'(`INTLV_CREDITS);
    end else begin
      case ({issue, out_credit})
        2'b10:   credits_q <= credits_q - 1'b1;  // spent on issue
        2'b01:   credits_q <= credits_q + 1'b1;  // returned by sink
        default: credits_q <= credits_q;         // both cancel out
      endcase
    end
  end

  // --------------------
  // output stage
  // --------------------

  always_ff @(posedge iwclk) begin
    if (!rst_n)
      out_valid <= 1'b0;
    else
      out_valid <= issue;  // lines up with ram data
  end

  // tag captured before release can move the read pointer
  always_ff @(posedge iwclk) begin
    if (issue)
      tag_q <= rd.tag;
  end

  assign out_data = rd.dat;  // ram read is already registered
  assign out_tag  = tag_q;

endmodule

// ==== interleaver_top.sv ====
module interleaver_top (
  input  logic               iwclk,
  input  logic               rst_n,
  // input stream, valid/ready
  input  logic               in_valid,
  output logic               in_ready,
  input  intlv_pkg::sample_t in_data,
  input  intlv_pkg::tag_t    in_tag,
  // output stream, credit based
  output logic               out_valid,
  output intlv_pkg::sample_t out_data,
  output intlv_pkg::tag_t    out_tag,
  input  logic               out_credit
);

  // --------------------
  // internal buses
  // --------------------

  buf_wr_if wr_bus ();  // writer -> buffer
  buf_rd_if rd_bus ();  // buffer -> reader

  // --------------------
  // decode
  // --------------------

  frame_writer frame_writer_inst (
    .iwclk    (iwclk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_data  (in_data),
    .in_tag   (in_tag),
    .wr       (wr_bus.writer)
  );

  // --------------------
  // execute
  // --------------------

  // ping-pong frame store
  codec_abuffer codec_abuffer_inst (
    .iwclk (iwclk),
    .rst_n (rst_n),
    .wr    (wr_bus.buffer),
    .rd    (rd_bus.buffer)
  );

  // --------------------
  // result
  // --------------------

  frame_reader frame_reader_inst (
    .iwclk      (iwclk),
    .rst_n      (rst_n),
    .rd         (rd_bus.reader),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_tag    (out_tag),
    .out_credit (out_credit)
  );

endmodule

// ==== tb_interleaver.sv ====
`include "intlv_defs.svh"

module tb_interleaver;
  timeunit 1ns;
  timeprecision 1ps;
  import intlv_pkg::*;

  localparam int ROWS         = `INTLV_ROWS;
  localparam int COLS         = `INTLV_COLS;
  localparam int FRAME        = ROWS * COLS;
  localparam int CYCLE_LIMIT  = 4 * FRAME * 4 + 500;  // 4 frames at 4 cycles a sample
  localparam int QUIET_CYCLES = 16;  // idle window after the last expected word
  localparam int CREDIT_HOLD  = 0;   // sink keeps every credit
  localparam int CREDIT_NOW   = 1;   // credit back as soon as a word is seen
  localparam int CREDIT_RAND  = 2;   // credit back after an lfsr delay

  logic        iwclk = 1'b0;
  logic        rst_n;
  logic        in_valid;
  logic        in_ready;
  sample_t     in_data;
  tag_t        in_tag;
  logic        out_valid;
  sample_t     out_data;
  tag_t        out_tag;
  logic        out_credit = 1'b0;

  sample_t     exp_data [$];      // expected words in interleaved order
  tag_t        exp_tag [$];
  sample_t     rx_data [$];       // words seen by the monitor
  tag_t        rx_tag [$];
  sample_t     frame_buf [FRAME]; // next frame in row-major order
  int          cmp_idx = 0;
  int          rx_total = 0;
  int          owed = 0;          // words not yet credited back
  int          credits_given = 0;
  int          credit_mode = CREDIT_NOW;
  int          cycles = 0;
  int          mismatches = 0;
  int          fails = 0;
  int          mon_fails = 0;
  logic        give;
  logic [15:0] stim_lfsr = 16'd13;
  logic [15:0] credit_lfsr = 16'd13;

  interleaver_top interleaver_top_inst (
    .iwclk      (iwclk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_data    (in_data),
    .in_tag     (in_tag),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_tag    (out_tag),
    .out_credit (out_credit)
  );

  always #50 iwclk = ~iwclk;  // 100 ns period

  // --------------------
  // galois lfsr x^16+x^14+x^13+x^11+1
  // --------------------

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic int unsigned stim_bits(input int n);
    int unsigned v;
    int          i;
    v = 0;
    for (i = 0; i < n; i++) begin
      stim_lfsr = lfsr_next(stim_lfsr);  // one step per bit
      v = {v[30:0], stim_lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic credit_bit();
    credit_lfsr = lfsr_next(credit_lfsr);
    return credit_lfsr[0];
  endfunction

  // run limit
  always @(posedge iwclk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the tests did not finish", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // --------------------
  // output monitor and credit sink
  // --------------------

  always @(negedge iwclk) begin
    if (rst_n && out_valid === 1'b1) begin
      rx_data.push_back(out_data);
      rx_tag.push_back(out_tag);
      rx_total = rx_total + 1;
      owed = owed + 1;
      if (rx_total > credits_given + `INTLV_CREDITS) begin  // sink overrun
        mon_fails = mon_fails + 1;
        $display("at %0t word %0d arrived with only %0d credits granted",
                 $time, rx_total, credits_given + `INTLV_CREDITS);
      end
    end
    give = 1'b0;
    if (rst_n && owed > 0) begin
      if (credit_mode == CREDIT_NOW)
        give = 1'b1;
      else if (credit_mode == CREDIT_RAND)
        give = credit_bit();  // coin flip per cycle
    end
    out_credit = give;
    if (give) begin
      owed = owed - 1;
      credits_given = credits_given + 1;
    end
  end

  // --------------------
  // compare tasks
  // --------------------

  task automatic check_sample(input sample_t got, input sample_t exp, input string what);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_tag(input tag_t got, input tag_t exp, input string what);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // --------------------
  // stimulus helpers for the falling edge
  // --------------------

  task automatic push_sample(input sample_t d, input tag_t t);
    in_valid = 1'b1;
    in_data  = d;
    in_tag   = t;
    while (!in_ready)
      @(negedge iwclk);  // held until a bank is free
    @(negedge iwclk);    // transfer on the edge in between
    in_valid = 1'b0;
  endtask

  task automatic fill_ramp(input int base, input int step);
    int i;
    for (i = 0; i < FRAME; i++)
      frame_buf[i] = sample_t'(base + i * step);
  endtask

  task automatic send_frame(input tag_t tag, input bit gaps);
    int k;
    for (k = 0; k < FRAME; k++) begin
      exp_data.push_back(frame_buf[(k % ROWS) * COLS + k / ROWS]);  // row k%4 col k/4
      exp_tag.push_back(tag);
    end
    for (k = 0; k < FRAME; k++) begin
      push_sample(frame_buf[k], tag);
      if (gaps)
        repeat (stim_bits(2)) @(negedge iwclk);
    end
  endtask

  task automatic wait_words();
    while (rx_total < exp_data.size())
      @(negedge iwclk);
  endtask

  task automatic compare_words();
    repeat (QUIET_CYCLES) @(negedge iwclk);  // a stray extra word shows up here
    while (cmp_idx < exp_data.size()) begin
      check_sample(rx_data[cmp_idx], exp_data[cmp_idx], $sformatf("word %0d data", cmp_idx));
      check_tag(rx_tag[cmp_idx], exp_tag[cmp_idx], $sformatf("word %0d tag", cmp_idx));
      cmp_idx++;
    end
    if (rx_total != exp_data.size()) begin
      fails++;
      $display("got %0d output words where %0d were expected", rx_total, exp_data.size());
    end
  endtask

  // --------------------
  // directed tests
  // --------------------

  task automatic test_reset_state();
    repeat (10) begin
      @(negedge iwclk);
      check_flag(in_ready, 1'b1, "in_ready after reset");
      check_flag(out_valid, 1'b0, "out_valid after reset");
    end
  endtask

  task automatic test_single_frame();
    fill_ramp(3, 7);
    send_frame(8'h11, 1'b0);
    wait_words();
    compare_words();
  endtask

  task automatic test_credit_limit();
    int base;
    base = rx_total;
    credit_mode = CREDIT_HOLD;
    fill_ramp(255, -1);
    send_frame(8'h22, 1'b0);
    while (rx_total < base + `INTLV_CREDITS)
      @(negedge iwclk);
    repeat (20) @(negedge iwclk);  // reader must stay stalled
    if (rx_total - base != `INTLV_CREDITS) begin
      fails++;
      $display("%0d words came out with credits withheld, %0d allowed",
               rx_total - base, `INTLV_CREDITS);
    end
    credit_mode = CREDIT_NOW;
    wait_words();
    compare_words();
  endtask

  task automatic test_bank_full();
    credit_mode = CREDIT_HOLD;
    fill_ramp(0, 3);
    send_frame(8'h33, 1'b0);
    fill_ramp(100, 1);
    send_frame(8'h44, 1'b0);
    in_valid = 1'b1;  // first sample of a third frame
    in_data  = 8'h55;
    in_tag   = 8'h55;
    repeat (8) begin
      check_flag(in_ready, 1'b0, "in_ready with both banks full");
      @(negedge iwclk);
    end
    credit_mode = CREDIT_NOW;
    while (!in_ready)
      @(negedge iwclk);
    in_valid = 1'b0;  // withdrawn before the next edge so never accepted
    wait_words();
    compare_words();
  endtask

  task automatic test_streaming();
    int f;
    int i;
    credit_mode = CREDIT_RAND;
    for (f = 0; f < 3; f++) begin
      for (i = 0; i < FRAME; i++)
        frame_buf[i] = sample_t'(stim_bits(8));
      send_frame(tag_t'(8'h60 + f), 1'b1);
    end
    wait_words();
    compare_words();
  endtask

  initial begin
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_data  = '0;
    in_tag   = '0;
    repeat (5) @(posedge iwclk);
    @(negedge iwclk);
    rst_n = 1'b1;
    test_reset_state();
    test_single_frame();
    test_credit_limit();
    test_bank_full();
    test_streaming();
    $display("summary: %0d mismatches, %0d other errors", mismatches, fails + mon_fails);
    if (mismatches == 0 && fails + mon_fails == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+.
intlv_pkg.sv
intlv_if.sv
bank_logic.sv
frame_ram.sv
codec_abuffer.sv
frame_writer.sv
frame_reader.sv
interleaver_top.sv
tb_interleaver.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f tb.f --top-module tb_interleaver -o sim_interleaver

./obj_dir/sim_interleaver | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"
